// ==== rtl/eeprom_settings.svh ====
`ifndef EEPROM_SETTINGS_SVH
`define EEPROM_SETTINGS_SVH

// word address of a 2 KB part
`define EEPROM_ADDR_W 11

`define EEPROM_DATA_W 8

// fixed code in the upper nibble of the control byte
`define EEPROM_DEV_CODE 4'b1010

// CLK cycles per SCL half period, at least 2
`define EEPROM_SCL_HALF 4

`endif

// ==== rtl/eeprom_pkg.sv ====
`include "eeprom_settings.svh"

package eeprom_pkg;

    typedef logic [`EEPROM_ADDR_W-1:0] addr_t;
    typedef logic [`EEPROM_DATA_W-1:0] byte_t;

    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } op_e;

    // host request
    typedef struct packed {
        op_e   op;
        addr_t addr;
        byte_t wdata;
    } req_t;

    typedef enum logic [1:0] {
        CMD_START,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } bit_cmd_e;

    typedef struct packed {
        bit_cmd_e cmd;
        byte_t    tx_byte;
        logic     last;     // answer read byte with NACK
    } bit_cmd_t;

    typedef enum logic [3:0] {
        SEQ_IDLE,
        SEQ_START,
        SEQ_CTRL_WR,
        SEQ_ADDR,
        SEQ_DATA,
        SEQ_RESTART,
        SEQ_CTRL_RD,
        SEQ_READ,
        SEQ_STOP,
        SEQ_FINISH
    } seq_state_e;

    typedef enum logic [2:0] {
        BIT_IDLE,
        BIT_START,
        BIT_STOP,
        BIT_SHIFT,
        BIT_ACK
    } bit_state_e;

endpackage

// ==== rtl/i2c_bit_engine.sv ====
`timescale 1ns/100ps
`include "eeprom_settings.svh"

module i2c_bit_engine
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 cmd_valid,
    input  eeprom_pkg::bit_cmd_t cmd,
    output logic                 cmd_ready,
    output logic                 bit_done,
    output eeprom_pkg::byte_t    rx_byte,
    output logic                 ack_ok,
    output logic                 scl,
    output logic                 sda_low,
    input  logic                 sda_in
);

    localparam int unsigned HALF = `EEPROM_SCL_HALF;
    localparam int unsigned CW = $clog2(HALF);
    localparam logic [CW-1:0] HALF_LAST = CW'(HALF - 1);

    eeprom_pkg::bit_state_e state;
    eeprom_pkg::bit_cmd_e   cur_cmd;
    eeprom_pkg::byte_t      shreg;
    logic                   cur_last;
    logic [CW-1:0]          hcnt;
    logic                   phase;      // 0 = first half, 1 = second half
    logic [2:0]             bit_cnt;
    logic                   tick;
    logic                   first;
    logic                   take;

    assign tick      = (hcnt == HALF_LAST);
    assign first     = (hcnt == '0);
    assign cmd_ready = (state == eeprom_pkg::BIT_IDLE);
    assign take      = cmd_valid && cmd_ready;
    assign rx_byte   = shreg;

    // latched command and shift register
    always_ff @(posedge CLK)
    begin
        if (take)
        begin
            cur_cmd  <= cmd.cmd;
            cur_last <= cmd.last;
            shreg    <= cmd.tx_byte;
        end
        else if (state == eeprom_pkg::BIT_SHIFT && phase)
        begin
            if (cur_cmd == eeprom_pkg::CMD_READ && first)
                shreg <= {shreg[`EEPROM_DATA_W-2:0], sda_in};   // sample just after SCL rise
            else if (cur_cmd == eeprom_pkg::CMD_WRITE && tick)
                shreg <= {shreg[`EEPROM_DATA_W-2:0], 1'b0};
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= eeprom_pkg::BIT_IDLE;
            hcnt     <= '0;
            phase    <= 1'b0;
            bit_cnt  <= '0;
            scl      <= 1'b1;
            sda_low  <= 1'b0;
            bit_done <= 1'b0;
            ack_ok   <= 1'b0;
        end
        else
        begin
            bit_done <= 1'b0;
            if (state != eeprom_pkg::BIT_IDLE)
                hcnt <= tick ? '0 : hcnt + 1'b1;

            case (state)
                eeprom_pkg::BIT_IDLE:
                    if (take)
                    begin
                        phase   <= 1'b0;
                        bit_cnt <= 3'd7;
                        case (cmd.cmd)
                            eeprom_pkg::CMD_START:
                            begin
                                sda_low <= 1'b0;    // release first, SCL may still be low
                                state   <= eeprom_pkg::BIT_START;
                            end
                            eeprom_pkg::CMD_STOP:
                            begin
                                sda_low <= 1'b1;
                                state   <= eeprom_pkg::BIT_STOP;
                            end
                            default:
                                state <= eeprom_pkg::BIT_SHIFT;
                        endcase
                    end

                eeprom_pkg::BIT_START:
                begin
                    if (!phase && first)
                        scl <= 1'b1;
                    if (tick)
                    begin
                        if (!phase)
                        begin
                            sda_low <= 1'b1;    // SDA falls with SCL high
                            phase   <= 1'b1;
                        end
                        else
                        begin
                            scl      <= 1'b0;
                            phase    <= 1'b0;
                            bit_done <= 1'b1;
                            state    <= eeprom_pkg::BIT_IDLE;
                        end
                    end
                end

                eeprom_pkg::BIT_STOP:
                begin
                    if (!phase && first)
                        scl <= 1'b1;
                    if (tick)
                    begin
                        if (!phase)
                        begin
                            sda_low <= 1'b0;    // SDA rises with SCL high
                            phase   <= 1'b1;
                        end
                        else
                        begin
                            phase    <= 1'b0;
                            bit_done <= 1'b1;
                            state    <= eeprom_pkg::BIT_IDLE;
                        end
                    end
                end

                eeprom_pkg::BIT_SHIFT, eeprom_pkg::BIT_ACK:
                begin
                    // SDA only moves one clock into the low half
                    if (!phase && first)
                    begin
                        if (state == eeprom_pkg::BIT_SHIFT)
                            sda_low <= (cur_cmd == eeprom_pkg::CMD_WRITE) &&
                                       !shreg[`EEPROM_DATA_W-1];
                        else
                            sda_low <= (cur_cmd == eeprom_pkg::CMD_READ) && !cur_last;
                    end
                    if (state == eeprom_pkg::BIT_ACK && phase && first &&
                        cur_cmd == eeprom_pkg::CMD_WRITE)
                        ack_ok <= !sda_in;
                    if (tick)
                    begin
                        if (!phase)
                        begin
                            scl   <= 1'b1;
                            phase <= 1'b1;
                        end
                        else
                        begin
                            scl   <= 1'b0;
                            phase <= 1'b0;
                            if (state == eeprom_pkg::BIT_ACK)
                            begin
                                bit_done <= 1'b1;
                                state    <= eeprom_pkg::BIT_IDLE;
                            end
                            else if (bit_cnt == 3'd0)
                                state <= eeprom_pkg::BIT_ACK;  // ninth clock
                            else
                                bit_cnt <= bit_cnt - 3'd1;
                        end
                    end
                end

                default:
                    state <= eeprom_pkg::BIT_IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/eeprom_sequencer.sv ====
`timescale 1ns/100ps
`include "eeprom_settings.svh"

module eeprom_sequencer
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 req_valid,
    input  eeprom_pkg::req_t     req,
    output logic                 busy,
    output logic                 done,
    output eeprom_pkg::byte_t    rdata,
    output logic                 error,
    output logic                 cmd_valid,
    output eeprom_pkg::bit_cmd_t cmd,
    input  logic                 cmd_ready,
    input  logic                 bit_done,
    input  eeprom_pkg::byte_t    rx_byte,
    input  logic                 ack_ok
);

    eeprom_pkg::seq_state_e state;
    eeprom_pkg::req_t       req_q;
    eeprom_pkg::byte_t      rd_q;
    logic                   issued;     // command of this state handed over
    logic                   err_acc;
    logic                   take;
    logic                   cmd_state;
    logic [2:0]             blk;

    assign busy = (state != eeprom_pkg::SEQ_IDLE) && (state != eeprom_pkg::SEQ_FINISH);
    assign done = (state == eeprom_pkg::SEQ_FINISH);
    assign take = req_valid && !busy;
    assign blk  = req_q.addr[`EEPROM_ADDR_W-1:8];

    assign cmd_state = busy;    // every busy state issues exactly one command
    assign cmd_valid = cmd_state && !issued;

    always_comb
    begin
        cmd.cmd     = eeprom_pkg::CMD_WRITE;
        cmd.tx_byte = '0;
        cmd.last    = 1'b0;
        case (state)
            eeprom_pkg::SEQ_START, eeprom_pkg::SEQ_RESTART:
                cmd.cmd = eeprom_pkg::CMD_START;
            eeprom_pkg::SEQ_CTRL_WR:
                cmd.tx_byte = {`EEPROM_DEV_CODE, blk, 1'b0};
            eeprom_pkg::SEQ_ADDR:
                cmd.tx_byte = req_q.addr[7:0];
            eeprom_pkg::SEQ_DATA:
                cmd.tx_byte = req_q.wdata;
            eeprom_pkg::SEQ_CTRL_RD:
                cmd.tx_byte = {`EEPROM_DEV_CODE, blk, 1'b1};
            eeprom_pkg::SEQ_READ:
            begin
                cmd.cmd  = eeprom_pkg::CMD_READ;
                cmd.last = 1'b1;    // single byte, master NACK
            end
            eeprom_pkg::SEQ_STOP:
                cmd.cmd = eeprom_pkg::CMD_STOP;
            default:
                cmd.cmd = eeprom_pkg::CMD_WRITE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (take)
            req_q <= req;
        if (state == eeprom_pkg::SEQ_READ && bit_done)
            rd_q <= rx_byte;
        if (state == eeprom_pkg::SEQ_STOP && bit_done &&
            req_q.op == eeprom_pkg::OP_READ && !err_acc)
            rdata <= rd_q;  // published together with done
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= eeprom_pkg::SEQ_IDLE;
            issued  <= 1'b0;
            err_acc <= 1'b0;
            error   <= 1'b0;
        end
        else
        begin
            if (bit_done)
                issued <= 1'b0;
            else if (cmd_valid && cmd_ready)
                issued <= 1'b1;

            case (state)
                eeprom_pkg::SEQ_IDLE, eeprom_pkg::SEQ_FINISH:
                    if (take)
                    begin
                        err_acc <= 1'b0;
                        state   <= eeprom_pkg::SEQ_START;
                    end
                    else
                        state <= eeprom_pkg::SEQ_IDLE;

                eeprom_pkg::SEQ_START:
                    if (bit_done)
                        state <= eeprom_pkg::SEQ_CTRL_WR;

                eeprom_pkg::SEQ_CTRL_WR:
                    if (bit_done)
                    begin
                        if (!ack_ok)
                        begin
                            err_acc <= 1'b1;    // no device in this block
                            state   <= eeprom_pkg::SEQ_STOP;
                        end
                        else
                            state <= eeprom_pkg::SEQ_ADDR;
                    end

                eeprom_pkg::SEQ_ADDR:
                    if (bit_done)
                    begin
                        if (!ack_ok)
                        begin
                            err_acc <= 1'b1;
                            state   <= eeprom_pkg::SEQ_STOP;
                        end
                        else if (req_q.op == eeprom_pkg::OP_READ)
                            state <= eeprom_pkg::SEQ_RESTART;
                        else
                            state <= eeprom_pkg::SEQ_DATA;
                    end

                eeprom_pkg::SEQ_DATA:
                    if (bit_done)
                    begin
                        err_acc <= err_acc || !ack_ok;
                        state   <= eeprom_pkg::SEQ_STOP;
                    end

                eeprom_pkg::SEQ_RESTART:
                    if (bit_done)
                        state <= eeprom_pkg::SEQ_CTRL_RD;

                eeprom_pkg::SEQ_CTRL_RD:
                    if (bit_done)
                    begin
                        if (!ack_ok)
                        begin
                            err_acc <= 1'b1;
                            state   <= eeprom_pkg::SEQ_STOP;
                        end
                        else
                            state <= eeprom_pkg::SEQ_READ;
                    end

                eeprom_pkg::SEQ_READ:
                    if (bit_done)
                        state <= eeprom_pkg::SEQ_STOP;

                eeprom_pkg::SEQ_STOP:
                    if (bit_done)
                    begin
                        error <= err_acc;
                        state <= eeprom_pkg::SEQ_FINISH;
                    end

                default:
                    state <= eeprom_pkg::SEQ_IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/eeprom_ctrl_top.sv ====
`timescale 1ns/100ps

module eeprom_ctrl_top
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              req_valid,
    input  eeprom_pkg::req_t  req,
    output logic              busy,
    output logic              done,
    output eeprom_pkg::byte_t rdata,
    output logic              error,
    output logic              scl,
    output logic              sda_low,
    input  logic              sda_in
);

    // command channel
    logic                 cmd_valid;
    logic                 cmd_ready;
    eeprom_pkg::bit_cmd_t cmd;
    logic                 bit_done;
    eeprom_pkg::byte_t    rx_byte;
    logic                 ack_ok;

    eeprom_sequencer seq_i
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .done      (done),
        .rdata     (rdata),
        .error     (error),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .bit_done  (bit_done),
        .rx_byte   (rx_byte),
        .ack_ok    (ack_ok)
    );

    i2c_bit_engine bit_i
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .bit_done  (bit_done),
        .rx_byte   (rx_byte),
        .ack_ok    (ack_ok),
        .scl       (scl),
        .sda_low   (sda_low),
        .sda_in    (sda_in)
    );

endmodule

// ==== testbench/eeprom_model.sv ====
`timescale 1ns/100ps
`include "eeprom_settings.svh"

module eeprom_model
(
    input  logic scl,
    input  logic sda,
    output logic sda_low
);

    localparam int MEM_SIZE = 1 << `EEPROM_ADDR_W;

    typedef enum {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_DATA,
        M_SEND
    } mode_e;

    eeprom_pkg::byte_t mem [MEM_SIZE];
    eeprom_pkg::byte_t rx;
    eeprom_pkg::byte_t tx;
    eeprom_pkg::addr_t addr;
    mode_e             mode;
    int                cnt;         // SCL rises seen in the current byte
    logic              acked;
    logic              rw;
    logic              last_bit;

    initial
    begin
        for (int a = 0; a < MEM_SIZE; a++)
            mem[a] = 8'hFF;
        mode     = M_IDLE;
        cnt      = 0;
        sda_low  = 1'b0;
        addr     = '0;
        acked    = 1'b0;
        rw       = 1'b0;
        last_bit = 1'b1;
    end

    // start or repeated start
    always @(negedge sda)
        if (scl === 1'b1)
        begin
            mode = M_CTRL;
            cnt  = 0;
        end

    always @(posedge sda)
        if (scl === 1'b1)
            mode = M_IDLE;  // stop

    always @(posedge scl)
        if (mode != M_IDLE)
        begin
            rx       = {rx[6:0], sda};
            last_bit = sda;
            cnt      = cnt + 1;
        end

    // the slave only moves SDA while SCL is low
    always @(negedge scl)
    begin
        case (mode)
            M_CTRL, M_ADDR, M_DATA:
                if (cnt == 8)
                begin
                    acked = 1'b1;
                    if (mode == M_CTRL)
                    begin
                        acked = (rx[7:4] == `EEPROM_DEV_CODE) && (rx[3:1] != 3'b111);
                        rw    = rx[0];
                        if (acked)
                            addr = {rx[3:1], addr[7:0]};    // block bits are the upper address
                    end
                    else if (mode == M_ADDR)
                        addr = {addr[`EEPROM_ADDR_W-1:8], rx};
                    else
                    begin
                        mem[addr] = rx;
                        addr      = addr + 1'b1;
                    end
                    sda_low = acked;
                end
                else if (cnt == 9)
                begin
                    cnt     = 0;
                    sda_low = 1'b0;
                    if (!acked)
                        mode = M_IDLE;
                    else if (mode == M_CTRL && rw)
                    begin
                        tx      = mem[addr];
                        sda_low = !tx[7];
                        mode    = M_SEND;
                    end
                    else if (mode == M_CTRL)
                        mode = M_ADDR;
                    else
                        mode = M_DATA;
                end

            M_SEND:
                if (cnt == 9)
                begin
                    cnt = 0;
                    if (last_bit)
                        mode = M_IDLE;  // master NACK
                    else
                    begin
                        addr    = addr + 1'b1;
                        tx      = mem[addr];
                        sda_low = !tx[7];
                    end
                end
                else if (cnt == 8)
                    sda_low = 1'b0;     // master acknowledges
                else if (cnt > 0)
                    sda_low = !tx[7 - cnt];

            default:
                sda_low = 1'b0;
        endcase
    end

endmodule

// ==== testbench/tb_eeprom_ctrl.sv ====
`timescale 1ns/100ps
`include "eeprom_settings.svh"

module tb_eeprom_ctrl;

    localparam int NUM_STEPS  = 34;
    localparam int MAX_CYCLES = NUM_STEPS * 1000;    // longest read is about 360
    localparam int MEM_SIZE   = 1 << `EEPROM_ADDR_W;

    localparam eeprom_pkg::op_e WR = eeprom_pkg::OP_WRITE;
    localparam eeprom_pkg::op_e RD = eeprom_pkg::OP_READ;

    typedef struct packed {
        eeprom_pkg::op_e   op;
        eeprom_pkg::addr_t addr;
        eeprom_pkg::byte_t wdata;
        eeprom_pkg::byte_t exp_rdata;
        logic              exp_err;
        logic              rnd;     // xorshift data and expected value from ref_mem
        logic              poke;    // second request while busy
    } step_t;

    logic              CLK;
    logic              RESET;
    logic              req_valid;
    eeprom_pkg::req_t  req;
    logic              busy;
    logic              done;
    eeprom_pkg::byte_t rdata;
    logic              error;
    logic              scl;
    logic              dut_sda_low;
    logic              model_sda_low;
    logic              sda;

    step_t             steps [NUM_STEPS];
    eeprom_pkg::byte_t ref_mem [MEM_SIZE];
    logic [31:0]       rng;
    int                errors;
    int                cycles = 0;

    assign sda = !(dut_sda_low || model_sda_low);  // pull-up with wired low

    eeprom_ctrl_top dut_i
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .done      (done),
        .rdata     (rdata),
        .error     (error),
        .scl       (scl),
        .sda_low   (dut_sda_low),
        .sda_in    (sda)
    );

    eeprom_model model_i
    (
        .scl     (scl),
        .sda     (sda),
        .sda_low (model_sda_low)
    );

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic step_t make_step(input eeprom_pkg::op_e op,
                                        input eeprom_pkg::addr_t addr,
                                        input eeprom_pkg::byte_t wdata,
                                        input eeprom_pkg::byte_t exp_rdata,
                                        input logic exp_err,
                                        input logic rnd,
                                        input logic poke);
        step_t s;
        s.op        = op;
        s.addr      = addr;
        s.wdata     = wdata;
        s.exp_rdata = exp_rdata;
        s.exp_err   = exp_err;
        s.rnd       = rnd;
        s.poke      = poke;
        return s;
    endfunction

    task automatic build_table();
        // one block per address, 0 through 6
        steps[0]  = make_step(WR, 11'h012, 8'hA5, 8'h00, 1'b0, 1'b0, 1'b0);
        steps[1]  = make_step(RD, 11'h012, 8'h00, 8'hA5, 1'b0, 1'b0, 1'b0);
        steps[2]  = make_step(WR, 11'h1C3, 8'h3C, 8'h00, 1'b0, 1'b0, 1'b0);
        steps[3]  = make_step(RD, 11'h1C3, 8'h00, 8'h3C, 1'b0, 1'b0, 1'b0);
        steps[4]  = make_step(WR, 11'h2F0, 8'h81, 8'h00, 1'b0, 1'b0, 1'b0);
        steps[5]  = make_step(WR, 11'h3A7, 8'h7E, 8'h00, 1'b0, 1'b0, 1'b0);
        steps[6]  = make_step(WR, 11'h455, 8'hC4, 8'h00, 1'b0, 1'b0, 1'b0);
        steps[7]  = make_step(WR, 11'h50F, 8'h19, 8'h00, 1'b0, 1'b0, 1'b0);
        steps[8]  = make_step(WR, 11'h6FE, 8'hE2, 8'h00, 1'b0, 1'b0, 1'b0);
        steps[9]  = make_step(RD, 11'h2F0, 8'h00, 8'h81, 1'b0, 1'b0, 1'b0);
        steps[10] = make_step(RD, 11'h3A7, 8'h00, 8'h7E, 1'b0, 1'b0, 1'b0);
        steps[11] = make_step(RD, 11'h455, 8'h00, 8'hC4, 1'b0, 1'b0, 1'b0);
        steps[12] = make_step(RD, 11'h50F, 8'h00, 8'h19, 1'b0, 1'b0, 1'b0);
        steps[13] = make_step(RD, 11'h6FE, 8'h00, 8'hE2, 1'b0, 1'b0, 1'b0);
        steps[14] = make_step(RD, 11'h0A0, 8'h00, 8'hFF, 1'b0, 1'b0, 1'b0);
        // block 7 has no device
        steps[15] = make_step(WR, 11'h734, 8'h55, 8'h00, 1'b1, 1'b0, 1'b0);
        steps[16] = make_step(RD, 11'h7C0, 8'h00, 8'h00, 1'b1, 1'b0, 1'b0);
        steps[17] = make_step(RD, 11'h012, 8'h00, 8'hA5, 1'b0, 1'b0, 1'b0);
        // poke writes 11'h140, which must stay unwritten
        steps[18] = make_step(WR, 11'h100, 8'h6B, 8'h00, 1'b0, 1'b0, 1'b1);
        steps[19] = make_step(RD, 11'h140, 8'h00, 8'hFF, 1'b0, 1'b0, 1'b0);
        steps[20] = make_step(RD, 11'h100, 8'h00, 8'h6B, 1'b0, 1'b0, 1'b0);
        steps[21] = make_step(WR, 11'h033, 8'h00, 8'h00, 1'b0, 1'b1, 1'b0);
        steps[22] = make_step(WR, 11'h1F1, 8'h00, 8'h00, 1'b0, 1'b1, 1'b0);
        steps[23] = make_step(WR, 11'h26C, 8'h00, 8'h00, 1'b0, 1'b1, 1'b0);
        steps[24] = make_step(WR, 11'h398, 8'h00, 8'h00, 1'b0, 1'b1, 1'b0);
        steps[25] = make_step(WR, 11'h4E2, 8'h00, 8'h00, 1'b0, 1'b1, 1'b0);
        steps[26] = make_step(WR, 11'h607, 8'h00, 8'h00, 1'b0, 1'b1, 1'b0);
        steps[27] = make_step(RD, 11'h033, 8'h00, 8'h00, 1'b0, 1'b1, 1'b0);
        steps[28] = make_step(RD, 11'h1F1, 8'h00, 8'h00, 1'b0, 1'b1, 1'b0);
        steps[29] = make_step(RD, 11'h26C, 8'h00, 8'h00, 1'b0, 1'b1, 1'b0);
        steps[30] = make_step(RD, 11'h398, 8'h00, 8'h00, 1'b0, 1'b1, 1'b0);
        steps[31] = make_step(RD, 11'h4E2, 8'h00, 8'h00, 1'b0, 1'b1, 1'b0);
        steps[32] = make_step(RD, 11'h607, 8'h00, 8'h00, 1'b0, 1'b1, 1'b0);
        // same low byte as 11'h012 in another block
        steps[33] = make_step(RD, 11'h212, 8'h00, 8'hFF, 1'b0, 1'b0, 1'b0);
    endtask

    // present a write while the current transaction runs
    task automatic request_while_busy(input eeprom_pkg::addr_t addr);
        eeprom_pkg::req_t r;
        r.op    = WR;
        r.addr  = addr;
        r.wdata = 8'h5A;
        @(negedge CLK);
        if (!busy)
        begin
            $display("[ERROR] %0t: busy low after the request was taken", $time);
            errors++;
        end
        @(posedge CLK);
        req_valid <= 1'b1;
        req       <= r;
        repeat (4) @(posedge CLK);
        req_valid <= 1'b0;
    endtask

    initial
    begin
        eeprom_pkg::req_t  r;
        eeprom_pkg::byte_t wdata;
        eeprom_pkg::byte_t exp;
        step_t             s;
        RESET     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        errors    = 0;
        rng       = 32'h30dc2a2c;
        for (int a = 0; a < MEM_SIZE; a++)
            ref_mem[a] = 8'hFF;
        build_table();

        repeat (7) @(posedge CLK);
        @(negedge CLK);
        if (busy || done || error || !scl || dut_sda_low)
        begin
            $display("[ERROR] %0t: outputs not idle during reset", $time);
            errors++;
        end
        @(posedge CLK);
        RESET <= 1'b0;

        for (int i = 0; i < NUM_STEPS; i++)
        begin
            s     = steps[i];
            wdata = s.wdata;
            if (s.rnd && s.op == WR)
            begin
                rng   = xorshift(rng);
                wdata = rng[7:0];
            end
            r.op    = s.op;
            r.addr  = s.addr;
            r.wdata = wdata;
            @(posedge CLK);
            req_valid <= 1'b1;
            req       <= r;
            @(posedge CLK);
            req_valid <= 1'b0;
            if (s.poke)
                request_while_busy(s.addr ^ 11'h040);
            do
                @(negedge CLK);
            while (!done);

            // absent block keeps the reference unchanged
            if (s.op == WR && s.addr[`EEPROM_ADDR_W-1:8] != 3'b111)
                ref_mem[s.addr] = wdata;
            exp = s.rnd ? ref_mem[s.addr] : s.exp_rdata;

            if (error !== s.exp_err)
            begin
                $display("[ERROR] %0t: step %0d error %b, expected %b",
                         $time, i, error, s.exp_err);
                errors++;
            end
            if (s.op == RD && !s.exp_err && rdata !== exp)
            begin
                $display("[ERROR] %0t: step %0d read %h at %h, expected %h",
                         $time, i, rdata, s.addr, exp);
                errors++;
            end
            if (scl !== 1'b1 || dut_sda_low !== 1'b0)
            begin
                $display("[ERROR] %0t: step %0d bus not idle after done", $time, i);
                errors++;
            end
        end

        $display("steps: %0d, errors: %0d", NUM_STEPS, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+rtl
rtl/eeprom_pkg.sv
rtl/i2c_bit_engine.sv
rtl/eeprom_sequencer.sv
rtl/eeprom_ctrl_top.sv
testbench/eeprom_model.sv
testbench/tb_eeprom_ctrl.sv

// ==== Bender.yml ====
package:
  name: eeprom_ctrl

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/eeprom_pkg.sv
      - rtl/i2c_bit_engine.sv
      - rtl/eeprom_sequencer.sv
      - rtl/eeprom_ctrl_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/eeprom_model.sv
      - testbench/tb_eeprom_ctrl.sv
